/* design/dump_pkg.sv */
`default_nettype none

package dump_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencer states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [3:0] {
        s_idle,
        s_load,
        s_begin_op,
        s_load_byte,
        s_wait_ready,
        s_send,
        s_wait_sent,
        s_next_byte,
        s_next_addr,
        s_finish
    } dump_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sweep and result geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    parameter int ADDR_WIDTH_DEFAULT = 8;
    parameter int RESULT_BYTES       = 4;

    // Right-shifting Galois LFSR, taps given in reflected form.
    parameter logic [31:0] LFSR_POLY      = 32'hEDB8_8320;
    // Keeps the seed away from zero for every address.
    parameter logic [31:0] LFSR_SEED_MASK = 32'hA5C3_0F96;

endpackage

`default_nettype wire

/* design/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    typedef enum logic [1:0] {
        u_idle,
        u_start_bit,
        u_data_bits,
        u_stop_bit
    } uart_state_t;

    // 8N1 framing.
    parameter int   DATA_BITS   = 8;
    parameter logic START_LEVEL = 1'b0;
    // The line idles at the stop level.
    parameter logic STOP_LEVEL  = 1'b1;

endpackage

`default_nettype wire

/* design/op_if.sv */
`default_nettype none

interface op_if import dump_pkg::*; #(
    parameter int ADDR_WIDTH = ADDR_WIDTH_DEFAULT
);
    logic                        beg;
    logic                        ready;
    logic                        ack;
    logic [ADDR_WIDTH-1:0]       address;
    logic [8*RESULT_BYTES-1:0]   result;

    // The engine answers one begin with one ready, cleared by ack.
    modport engine (
        input  beg,
        input  ack,
        input  address,
        output ready,
        output result
    );

    modport sequencer (
        output beg,
        output ack,
        input  ready
    );
endinterface

`default_nettype wire

/* design/sweep_counter.sv */
`default_nettype none

module sweep_counter #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             load,
    input  logic             enable,
    input  logic [WIDTH-1:0] load_value,
    input  logic [WIDTH-1:0] last_value,
    output logic [WIDTH-1:0] count,
    output logic             max_tick
);

    // Load only takes effect together with enable.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            count <= '0;
        end
        else if (enable)
        begin
            if (load)
                count <= load_value;
            else
                count <= count + 1'b1;
        end
    end

    assign max_tick = (count == last_value);

endmodule

`default_nettype wire

/* design/checksum_engine.sv */
`default_nettype none

module checksum_engine import dump_pkg::*; (
    input  logic clk,
    input  logic rst,
    op_if.engine op
);

    typedef enum logic [1:0] {
        e_idle,
        e_run,
        e_hold
    } eng_state_t;

    eng_state_t  state;
    logic [2:0]  steps_left;
    logic [31:0] lfsr;

    function automatic logic [31:0] lfsr_step(input logic [31:0] value);
        logic [31:0] shifted;
        shifted = value >> 1;
        if (value[0])
            shifted = shifted ^ LFSR_POLY;
        return shifted;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control. The run takes (address mod 8) + 1 steps.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state      <= e_idle;
            steps_left <= '0;
        end
        else
        begin
            case (state)
                e_idle:
                begin
                    if (op.beg)
                    begin
                        steps_left <= op.address[2:0];
                        state      <= e_run;
                    end
                end
                e_run:
                begin
                    if (steps_left == 3'd0)
                        state <= e_hold;
                    else
                        steps_left <= steps_left - 1'b1;
                end
                e_hold:
                begin
                    if (op.ack)
                        state <= e_idle;
                end
                default:
                    state <= e_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == e_idle && op.beg)
            lfsr <= 32'(op.address) ^ LFSR_SEED_MASK;
        else if (state == e_run)
            lfsr <= lfsr_step(lfsr);
    end

    assign op.ready  = (state == e_hold);
    assign op.result = lfsr;

endmodule

`default_nettype wire

/* design/uart_tx.sv */
`default_nettype none

module uart_tx import uart_pkg::*; #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    output logic       tx,
    output logic       tx_done
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam int IDX_W = $clog2(DATA_BITS);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(DATA_BITS - 1);

    uart_state_t      state;
    logic [CNT_W-1:0] clk_cnt;
    logic [IDX_W-1:0] bit_idx;
    logic [7:0]       shift_reg;
    logic             bit_end;

    assign bit_end = (clk_cnt == BIT_LAST);

    // The line is registered, so the start bit falls one cycle after tx_start.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= u_idle;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx      <= STOP_LEVEL;
            tx_done <= 1'b0;
        end
        else
        begin
            tx_done <= 1'b0;
            case (state)
                u_idle:
                begin
                    if (tx_start)
                    begin
                        clk_cnt <= '0;
                        tx      <= START_LEVEL;
                        state   <= u_start_bit;
                    end
                end
                u_start_bit:
                begin
                    if (bit_end)
                    begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        tx      <= shift_reg[0];
                        state   <= u_data_bits;
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                u_data_bits:
                begin
                    if (bit_end)
                    begin
                        clk_cnt <= '0;
                        if (bit_idx == IDX_LAST)
                        begin
                            tx    <= STOP_LEVEL;
                            state <= u_stop_bit;
                        end
                        else
                        begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shift_reg[1];
                        end
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                u_stop_bit:
                begin
                    if (bit_end)
                    begin
                        clk_cnt <= '0;
                        tx_done <= 1'b1;
                        state   <= u_idle;
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                default:
                    state <= u_idle;
            endcase
        end
    end

    // Data leaves LSB first.
    always_ff @(posedge clk)
    begin
        if (state == u_idle && tx_start)
            shift_reg <= tx_byte;
        else if (state == u_data_bits && bit_end)
            shift_reg <= {1'b0, shift_reg[7:1]};
    end

endmodule

`default_nettype wire

/* design/dump_sequencer.sv */
`default_nettype none

module dump_sequencer import dump_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    op_if.sequencer     op,
    input  logic        addr_max_tick,
    input  logic        byte_max_tick,
    output logic        load_addr,
    output logic        enab_addr,
    output logic        load_byte,
    output logic        enab_byte,
    output logic        tx_start,
    input  logic        tx_done,
    output logic        busy,
    output logic        done
);

    dump_state_t state_reg;
    dump_state_t state_next;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            state_reg <= s_idle;
        else
            state_reg <= state_next;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next state and Moore outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        state_next = state_reg;
        op.beg     = 1'b0;
        op.ack     = 1'b0;
        load_addr  = 1'b0;
        enab_addr  = 1'b0;
        load_byte  = 1'b0;
        enab_byte  = 1'b0;
        tx_start   = 1'b0;
        busy       = 1'b1;
        done       = 1'b0;
        case (state_reg)
            s_idle:
            begin
                busy = 1'b0;
                if (start)
                    state_next = s_load;
            end
            s_load:
            begin
                load_addr  = 1'b1;
                enab_addr  = 1'b1;
                state_next = s_begin_op;
            end
            s_begin_op:
            begin
                op.beg     = 1'b1;
                state_next = s_load_byte;
            end
            s_load_byte:
            begin
                // Begin stays high here, the engine has already taken it.
                op.beg     = 1'b1;
                load_byte  = 1'b1;
                enab_byte  = 1'b1;
                state_next = s_wait_ready;
            end
            s_wait_ready:
            begin
                if (op.ready)
                    state_next = s_send;
            end
            s_send:
            begin
                tx_start   = 1'b1;
                state_next = s_wait_sent;
            end
            s_wait_sent:
            begin
                if (tx_done)
                begin
                    if (byte_max_tick)
                        state_next = s_next_addr;
                    else
                        state_next = s_next_byte;
                end
            end
            s_next_byte:
            begin
                enab_byte  = 1'b1;
                state_next = s_send;
            end
            s_next_addr:
            begin
                // The last result is acknowledged too, so the engine is idle for the next run.
                op.ack    = 1'b1;
                enab_addr = 1'b1;
                if (addr_max_tick)
                    state_next = s_finish;
                else
                    state_next = s_begin_op;
            end
            s_finish:
            begin
                busy = 1'b0;
                done = 1'b1;
                if (start)
                    state_next = s_load;
            end
            default:
                state_next = s_idle;
        endcase
    end

endmodule

`default_nettype wire

/* design/result_dumper_top.sv */
`default_nettype none

module result_dumper_top import dump_pkg::*; #(
    parameter int ADDR_WIDTH   = ADDR_WIDTH_DEFAULT,
    parameter int CLKS_PER_BIT = 868
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic [ADDR_WIDTH-1:0] first_addr,
    input  logic [ADDR_WIDTH-1:0] last_addr,
    output logic                  tx,
    output logic                  busy,
    output logic                  done
);

    localparam int BYTE_W = $clog2(RESULT_BYTES);
    localparam logic [BYTE_W-1:0] BYTE_LAST = BYTE_W'(RESULT_BYTES - 1);

    logic                         load_addr;
    logic                         enab_addr;
    logic                         addr_max_tick;
    logic [ADDR_WIDTH-1:0]        addr_count;
    logic                         load_byte;
    logic                         enab_byte;
    logic                         byte_max_tick;
    logic [BYTE_W-1:0]            byte_count;
    logic [RESULT_BYTES-1:0][7:0] result_bytes;
    logic [7:0]                   tx_byte;
    logic                         tx_start;
    logic                         tx_done;

    op_if #(.ADDR_WIDTH(ADDR_WIDTH)) op ();

    dump_sequencer i_sequencer (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .op            (op.sequencer),
        .addr_max_tick (addr_max_tick),
        .byte_max_tick (byte_max_tick),
        .load_addr     (load_addr),
        .enab_addr     (enab_addr),
        .load_byte     (load_byte),
        .enab_byte     (enab_byte),
        .tx_start      (tx_start),
        .tx_done       (tx_done),
        .busy          (busy),
        .done          (done)
    );

    sweep_counter #(.WIDTH(ADDR_WIDTH)) i_addr_counter (
        .clk        (clk),
        .rst        (rst),
        .load       (load_addr),
        .enable     (enab_addr),
        .load_value (first_addr),
        .last_value (last_addr),
        .count      (addr_count),
        .max_tick   (addr_max_tick)
    );

    sweep_counter #(.WIDTH(BYTE_W)) i_byte_counter (
        .clk        (clk),
        .rst        (rst),
        .load       (load_byte),
        .enable     (enab_byte),
        .load_value ('0),
        .last_value (BYTE_LAST),
        .count      (byte_count),
        .max_tick   (byte_max_tick)
    );

    assign op.address = addr_count;

    checksum_engine i_engine (
        .clk (clk),
        .rst (rst),
        .op  (op.engine)
    );

    // Byte 0 is the least significant byte of the result.
    assign result_bytes = op.result;
    assign tx_byte      = result_bytes[byte_count];

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx       (tx),
        .tx_done  (tx_done)
    );

endmodule

`default_nettype wire

/* testbench/uart_rx_model.sv */
`default_nettype none

module uart_rx_model import uart_pkg::*; #(
    parameter int BIT_NS = 320
) (
    input  logic       rx,
    output logic [7:0] rx_byte,
    output int         rx_count,
    output int         frame_errors
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [DATA_BITS-1:0] data;

    // Each bit is sampled in its middle, half a bit after the falling start edge.
    initial
    begin
        rx_byte      = '0;
        rx_count     = 0;
        frame_errors = 0;
        data         = '0;
        forever
        begin
            @(negedge rx);
            #(BIT_NS / 2);
            if (rx !== START_LEVEL)
            begin
                $display("Frame error at %0t: start bit is not low", $time);
                frame_errors = frame_errors + 1;
            end
            for (int i = 0; i < DATA_BITS; i++)
            begin
                #(BIT_NS);
                data[i] = rx;
            end
            #(BIT_NS);
            if (rx !== STOP_LEVEL)
            begin
                $display("Frame error at %0t: stop bit is not high", $time);
                frame_errors = frame_errors + 1;
            end
            // The byte is in place before the count moves.
            rx_byte  = data;
            rx_count = rx_count + 1;
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_result_dumper.sv */
`default_nettype none

module tb_result_dumper import dump_pkg::*, uart_pkg::*;;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD    = 40;
    localparam int INPUT_DELAY   = 2;
    localparam int RESET_CYCLES  = 10;
    localparam int IDLE_CYCLES   = 20;
    localparam int POKE_DELAY    = 40;
    localparam int CLKS_PER_BIT  = 8;
    localparam int ADDR_WIDTH    = 8;
    localparam int FRAME_BITS    = DATA_BITS + 2;
    localparam int ENGINE_CYCLES = 2 + 7;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sweep table: first address, last address, extra start while busy
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int NUM_ROWS = 5;
    localparam logic [7:0] FIRST_TAB [NUM_ROWS] = '{8'h05, 8'h10, 8'h3E, 8'hF8, 8'h00};
    localparam logic [7:0] LAST_TAB  [NUM_ROWS] = '{8'h05, 8'h13, 8'h41, 8'hFF, 8'h00};
    localparam logic       POKE_TAB  [NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0};

    logic                  clk;
    logic                  rst;
    logic                  start;
    logic [ADDR_WIDTH-1:0] first_addr;
    logic [ADDR_WIDTH-1:0] last_addr;
    logic                  tx;
    logic                  busy;
    logic                  done;

    logic [7:0]            rx_byte;
    int                    rx_count;
    int                    frame_errors;
    logic [7:0]            got_bytes [$];

    result_dumper_top #(
        .ADDR_WIDTH   (ADDR_WIDTH),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .first_addr (first_addr),
        .last_addr  (last_addr),
        .tx         (tx),
        .busy       (busy),
        .done       (done)
    );

    uart_rx_model #(.BIT_NS(CLKS_PER_BIT * CLK_PERIOD)) i_rx_model (
        .rx           (tx),
        .rx_byte      (rx_byte),
        .rx_count     (rx_count),
        .frame_errors (frame_errors)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(rx_count)
    begin
        if (rx_count > 0)
            got_bytes.push_back(rx_byte);
    end

    // Galois LFSR shifting right, seeded from the address, (address mod 8) + 1 steps.
    function automatic logic [31:0] expected_result(input logic [7:0] addr);
        logic [31:0] value;
        value = {24'h0, addr} ^ LFSR_SEED_MASK;
        for (int n = 0; n <= int'(addr[2:0]); n++)
        begin
            if (value[0])
                value = (value >> 1) ^ LFSR_POLY;
            else
                value = value >> 1;
        end
        return value;
    endfunction

    function automatic longint timeout_ns();
        longint cycles;
        int     n_addr;
        cycles = RESET_CYCLES + IDLE_CYCLES;
        for (int row = 0; row < NUM_ROWS; row++)
        begin
            n_addr = int'(LAST_TAB[row]) - int'(FIRST_TAB[row]) + 1;
            cycles = cycles + n_addr * (RESULT_BYTES * FRAME_BITS * CLKS_PER_BIT
                                        + ENGINE_CYCLES);
        end
        return 2 * cycles * CLK_PERIOD;
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected)
        begin
            $display("** Error at %0t ns: %s: got %h, expected %h", $time, what, got,
                     expected);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #(INPUT_DELAY);
    endtask

    task automatic pulse_start();
        next_cycle();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One sweep: start, collect bytes, wait for done, compare
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_row(input int row);
        logic [7:0]  expected [$];
        logic [31:0] value;
        expected.delete();
        for (int a = int'(FIRST_TAB[row]); a <= int'(LAST_TAB[row]); a++)
        begin
            value = expected_result(a[7:0]);
            for (int b = 0; b < RESULT_BYTES; b++)
                expected.push_back(value[8*b +: 8]);
        end
        got_bytes.delete();

        first_addr = FIRST_TAB[row];
        last_addr  = LAST_TAB[row];
        pulse_start();
        check_equal(busy, 1'b1, "busy after start");
        check_equal(done, 1'b0, "done after start");

        // A start in the middle of a sweep must change nothing.
        if (POKE_TAB[row])
        begin
            repeat (POKE_DELAY)
                next_cycle();
            pulse_start();
            check_equal(busy, 1'b1, "busy after start during sweep");
        end

        while (done !== 1'b1)
            next_cycle();
        check_equal(busy, 1'b0, "busy at done");

        check_equal(got_bytes.size(), expected.size(), "byte count");
        foreach (expected[i])
            check_equal(got_bytes[i], expected[i], $sformatf("row %0d byte %0d", row, i));
        check_equal(frame_errors, 0, "frame errors");
    endtask

    initial
    begin
        clk        = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        first_addr = '0;
        last_addr  = '0;

        repeat (RESET_CYCLES)
            @(posedge clk);
        #(INPUT_DELAY);
        rst = 1'b0;

        // Quiet line before any start.
        repeat (IDLE_CYCLES)
        begin
            next_cycle();
            check_equal(tx, 1'b1, "tx idle");
            check_equal(busy, 1'b0, "busy idle");
            check_equal(done, 1'b0, "done idle");
        end

        for (int row = 0; row < NUM_ROWS; row++)
            run_row(row);

        $display("TEST PASS");
        $finish;
    end

    initial
    begin : watchdog
        longint limit_ns;
        limit_ns = timeout_ns();
        #(limit_ns);
        $display("Timeout: the sweeps did not finish within %0d ns", limit_ns);
        $display("TEST FAIL");
        $fatal(1);
    end

endmodule

`default_nettype wire

/* vlog.f */
design/dump_pkg.sv
design/uart_pkg.sv
design/op_if.sv
design/sweep_counter.sv
design/checksum_engine.sv
design/uart_tx.sv
design/dump_sequencer.sv
design/result_dumper_top.sv
testbench/uart_rx_model.sv
testbench/tb_result_dumper.sv

/* Bender.yml */
package:
  name: result_dumper

sources:
  - target: rtl
    files:
      - design/dump_pkg.sv
      - design/uart_pkg.sv
      - design/op_if.sv
      - design/sweep_counter.sv
      - design/checksum_engine.sv
      - design/uart_tx.sv
      - design/dump_sequencer.sv
      - design/result_dumper_top.sv

  - target: test
    files:
      - testbench/uart_rx_model.sv
      - testbench/tb_result_dumper.sv
